// ==== rtl/ps2_pkg.sv ====
package ps2_pkg;

	// modifier state held by the translation FSM.
	typedef struct packed {
		logic caps_lock;
		logic shift_l;
		logic shift_r;
		logic ctrl_l;
		logic ctrl_r;
	} key_mods_t;

	// lookup result, code is only meaningful when mapped is set.
	typedef struct packed {
		logic       mapped;
		logic [6:0] code;
	} ascii_res_t;

	// translation FSM states.
	typedef enum logic [1:0] {
		ready     = 2'd0,
		new_code  = 2'd1,
		translate = 2'd2,
		emit      = 2'd3
	} key_state_t;

	// prefix codes.
	localparam logic [7:0] code_break  = 8'hF0;
	localparam logic [7:0] code_ext    = 8'hE0;

	// modifier keys, right ctrl is code_ctrl behind code_ext.
	localparam logic [7:0] code_caps   = 8'h58;
	localparam logic [7:0] code_lshift = 8'h12;
	localparam logic [7:0] code_rshift = 8'h59;
	localparam logic [7:0] code_ctrl   = 8'h14;

endpackage

// ==== rtl/ps2_debounce.sv ====
`timescale 1ns/10ps

module ps2_debounce #(
	parameter int debounce_bits = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic raw,
	output logic clean
);

	logic sync_a;
	logic sync_b;
	logic [debounce_bits-1:0] stable_cnt;

	// two flop synchronizer.
	// idles high like the bus.
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= 1'b1;
			sync_b <= 1'b1;
		end else begin
			sync_a <= raw;
			sync_b <= sync_a;
		end
	end

	// count cycles the synced input differs from the output.
	// any glitch back to the old level restarts the count.
	always_ff @(posedge clk) begin
		if (rst) begin
			stable_cnt <= '0;
			clean <= 1'b1;
		end else if (sync_b == clean) begin
			stable_cnt <= '0;
		end else if (&stable_cnt) begin
			// held for 2^debounce_bits cycles, accept it.
			stable_cnt <= '0;
			clean <= sync_b;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/ps2_frame_rx.sv ====
`timescale 1ns/10ps

module ps2_frame_rx #(
	parameter int debounce_bits = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk_f,
	input  logic       ps2_data_f,
	output logic       ps2_code_new,
	output logic [7:0] ps2_code,
	output logic       frame_err
);

	logic clk_prev;
	logic fall;
	logic frame_ok;
	logic [9:0] shift_q;
	logic [10:0] frame;
	logic [3:0] bit_cnt;
	logic [debounce_bits+5:0] idle_cnt;

	assign fall = clk_prev & ~ps2_clk_f;

	// frame as it looks once the current bit is shifted in.
	// bit 0 start, 8:1 data, 9 parity, 10 stop.
	assign frame = {ps2_data_f, shift_q};

	// start low, stop high, odd parity over data and parity bit.
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_prev <= 1'b1;
		end else begin
			clk_prev <= ps2_clk_f;
		end
	end

	// lsb arrives first and new bits enter at the top.
	always_ff @(posedge clk) begin
		if (fall) begin
			shift_q <= frame[10:1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			ps2_code_new <= 1'b0;
			ps2_code <= '0;
			frame_err <= 1'b0;
		end else begin
			ps2_code_new <= 1'b0;
			frame_err <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					if (frame_ok) begin
						ps2_code_new <= 1'b1;
						ps2_code <= frame[8:1];
					end else begin
						frame_err <= 1'b1;
					end
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (bit_cnt != '0) begin
				// drop a partial frame after a long quiet clock.
				if (&idle_cnt) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== rtl/ps2_ascii_map.sv ====
`timescale 1ns/10ps

module ps2_ascii_map
	import ps2_pkg::*;
(
	input  logic [7:0] code,
	input  logic       ext,
	input  key_mods_t  mods,
	output ascii_res_t result
);

	logic ctrl;
	logic shift;
	logic upper;
	logic [4:0] lt_idx;
	logic [14:0] sym;
	ascii_res_t ctl_res;
	ascii_res_t plain_res;

	assign ctrl = mods.ctrl_l | mods.ctrl_r;
	assign shift = mods.shift_l | mods.shift_r;

	// shift and caps lock cancel each other for letters.
	assign upper = shift ^ mods.caps_lock;

	// letter index a..z, 31 when not a letter.
	always_comb begin
		case (code)
			8'h1C: lt_idx = 5'd0;
			8'h32: lt_idx = 5'd1;
			8'h21: lt_idx = 5'd2;
			8'h23: lt_idx = 5'd3;
			8'h24: lt_idx = 5'd4;
			8'h2B: lt_idx = 5'd5;
			8'h34: lt_idx = 5'd6;
			8'h33: lt_idx = 5'd7;
			8'h43: lt_idx = 5'd8;
			8'h3B: lt_idx = 5'd9;
			8'h42: lt_idx = 5'd10;
			8'h4B: lt_idx = 5'd11;
			8'h3A: lt_idx = 5'd12;
			8'h31: lt_idx = 5'd13;
			8'h44: lt_idx = 5'd14;
			8'h4D: lt_idx = 5'd15;
			8'h15: lt_idx = 5'd16;
			8'h2D: lt_idx = 5'd17;
			8'h1B: lt_idx = 5'd18;
			8'h2C: lt_idx = 5'd19;
			8'h3C: lt_idx = 5'd20;
			8'h2A: lt_idx = 5'd21;
			8'h1D: lt_idx = 5'd22;
			8'h22: lt_idx = 5'd23;
			8'h35: lt_idx = 5'd24;
			8'h1A: lt_idx = 5'd25;
			default: lt_idx = 5'd31;
		endcase
	end

	// digits and punctuation.
	// valid flag, plain symbol, shifted symbol.
	always_comb begin
		case (code)
			8'h45: sym = {1'b1, 7'h30, 7'h29};
			8'h16: sym = {1'b1, 7'h31, 7'h21};
			8'h1E: sym = {1'b1, 7'h32, 7'h40};
			8'h26: sym = {1'b1, 7'h33, 7'h23};
			8'h25: sym = {1'b1, 7'h34, 7'h24};
			8'h2E: sym = {1'b1, 7'h35, 7'h25};
			8'h36: sym = {1'b1, 7'h36, 7'h5E};
			8'h3D: sym = {1'b1, 7'h37, 7'h26};
			8'h3E: sym = {1'b1, 7'h38, 7'h2A};
			8'h46: sym = {1'b1, 7'h39, 7'h28};
			8'h52: sym = {1'b1, 7'h27, 7'h22};
			8'h41: sym = {1'b1, 7'h2C, 7'h3C};
			8'h4E: sym = {1'b1, 7'h2D, 7'h5F};
			8'h49: sym = {1'b1, 7'h2E, 7'h3E};
			8'h4A: sym = {1'b1, 7'h2F, 7'h3F};
			8'h4C: sym = {1'b1, 7'h3B, 7'h3A};
			8'h55: sym = {1'b1, 7'h3D, 7'h2B};
			8'h54: sym = {1'b1, 7'h5B, 7'h7B};
			8'h5D: sym = {1'b1, 7'h5C, 7'h7C};
			8'h5B: sym = {1'b1, 7'h5D, 7'h7D};
			8'h0E: sym = {1'b1, 7'h60, 7'h7E};
			default: sym = '0;
		endcase
	end

	// control codes from punctuation, ^@ and ^[ .. ^_.
	always_comb begin
		case (code)
			8'h1E: ctl_res = '{mapped: 1'b1, code: 7'h00};
			8'h54: ctl_res = '{mapped: 1'b1, code: 7'h1B};
			8'h5D: ctl_res = '{mapped: 1'b1, code: 7'h1C};
			8'h5B: ctl_res = '{mapped: 1'b1, code: 7'h1D};
			8'h36: ctl_res = '{mapped: 1'b1, code: 7'h1E};
			8'h4E: ctl_res = '{mapped: 1'b1, code: 7'h1F};
			default: ctl_res = '0;
		endcase
	end

	// keys that ignore modifiers.
	// 71 alone is the keypad dot, delete only behind E0.
	always_comb begin
		case (code)
			8'h29: plain_res = '{mapped: 1'b1, code: 7'h20};
			8'h66: plain_res = '{mapped: 1'b1, code: 7'h08};
			8'h0D: plain_res = '{mapped: 1'b1, code: 7'h09};
			8'h5A: plain_res = '{mapped: 1'b1, code: 7'h0D};
			8'h76: plain_res = '{mapped: 1'b1, code: 7'h1B};
			8'h71: plain_res = '{mapped: ext, code: 7'h7F};
			default: plain_res = '0;
		endcase
	end

	always_comb begin
		if (ctrl) begin
			if (lt_idx < 5'd26) begin
				result = '{mapped: 1'b1, code: 7'(lt_idx) + 7'd1};
			end else begin
				result = ctl_res;
			end
		end else if (lt_idx < 5'd26) begin
			result = '{mapped: 1'b1, code: (upper ? 7'h41 : 7'h61) + 7'(lt_idx)};
		end else if (sym[14]) begin
			result = '{mapped: 1'b1, code: shift ? sym[6:0] : sym[13:7]};
		end else begin
			result = plain_res;
		end
	end

endmodule

// ==== rtl/ps2_key_fsm.sv ====
`timescale 1ns/10ps

module ps2_key_fsm
	import ps2_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_code_new,
	input  logic [7:0] ps2_code,
	input  ascii_res_t lookup,
	output logic [7:0] code_q,
	output logic       ext,
	output key_mods_t  mods,
	output logic       ascii_new,
	output logic [6:0] ascii_code
);

	key_state_t state_q;
	logic brk;
	ascii_res_t res_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ready;
			code_q <= '0;
			brk <= 1'b0;
			ext <= 1'b0;
			mods <= '0;
			res_q <= '0;
			ascii_new <= 1'b0;
			ascii_code <= '0;
		end else begin
			ascii_new <= 1'b0;
			unique case (state_q)
				ready: begin
					if (ps2_code_new) begin
						code_q <= ps2_code;
						state_q <= new_code;
					end
				end

				new_code: begin
					// prefixes only set a flag for the next byte.
					if (code_q == code_break) begin
						brk <= 1'b1;
						state_q <= ready;
					end else if (code_q == code_ext) begin
						ext <= 1'b1;
						state_q <= ready;
					end else begin
						state_q <= translate;
					end
				end

				translate: begin
					// caps lock toggles on press, repeats toggle again.
					if (code_q == code_caps && !brk) begin
						mods.caps_lock <= ~mods.caps_lock;
					end
					if (code_q == code_lshift) begin
						mods.shift_l <= ~brk;
					end
					if (code_q == code_rshift) begin
						mods.shift_r <= ~brk;
					end
					if (code_q == code_ctrl) begin
						if (ext) begin
							mods.ctrl_r <= ~brk;
						end else begin
							mods.ctrl_l <= ~brk;
						end
					end

					// lookup sees the modifiers from before this key.
					res_q <= lookup;
					brk <= 1'b0;
					ext <= 1'b0;

					if (brk) begin
						state_q <= ready;
					end else begin
						state_q <= emit;
					end
				end

				emit: begin
					if (res_q.mapped) begin
						ascii_new <= 1'b1;
						ascii_code <= res_q.code;
					end
					state_q <= ready;
				end

				default: begin
					state_q <= ready;
				end
			endcase
		end
	end

endmodule

// ==== rtl/ps2_keyboard.sv ====
`timescale 1ns/10ps

module ps2_keyboard
	import ps2_pkg::*;
#(
	parameter int debounce_bits = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       ps2_code_new,
	output logic [7:0] ps2_code,
	output logic       frame_err,
	output logic       ascii_new,
	output logic [6:0] ascii_code
);

	logic ps2_clk_f;
	logic ps2_data_f;
	logic [7:0] code_q;
	logic ext;
	key_mods_t mods;
	ascii_res_t lookup;

	// both bus lines get the same filter.
	ps2_debounce #(
		.debounce_bits(debounce_bits)
	) clk_filt_i (
		.clk  (clk),
		.rst  (rst),
		.raw  (ps2_clk),
		.clean(ps2_clk_f)
	);

	ps2_debounce #(
		.debounce_bits(debounce_bits)
	) data_filt_i (
		.clk  (clk),
		.rst  (rst),
		.raw  (ps2_data),
		.clean(ps2_data_f)
	);

	ps2_frame_rx #(
		.debounce_bits(debounce_bits)
	) frame_rx_i (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk_f   (ps2_clk_f),
		.ps2_data_f  (ps2_data_f),
		.ps2_code_new(ps2_code_new),
		.ps2_code    (ps2_code),
		.frame_err   (frame_err)
	);

	ps2_key_fsm key_fsm_i (
		.clk         (clk),
		.rst         (rst),
		.ps2_code_new(ps2_code_new),
		.ps2_code    (ps2_code),
		.lookup      (lookup),
		.code_q      (code_q),
		.ext         (ext),
		.mods        (mods),
		.ascii_new   (ascii_new),
		.ascii_code  (ascii_code)
	);

	ps2_ascii_map ascii_map_i (
		.code  (code_q),
		.ext   (ext),
		.mods  (mods),
		.result(lookup)
	);

endmodule

// ==== include/ps2_tb_tasks.svh ====
// device side bus timing in system clock cycles.
localparam int half_period = 40;
localparam int frame_cycles = 24 * half_period;

// step n rising edges, then the drive offset.
task automatic wait_cycles(input int n);
	repeat (n) @(posedge clk);
	#2;
endtask

task automatic check_count(input string name, input int got, input int want);
	if (got != want) begin
		$display("ERR %s count: expected %h got %h", name, want, got);
		err_cnt++;
	end
endtask

// start, data lsb first, odd parity, stop.
// data moves while the bus clock is high.
task automatic send_frame(input logic [7:0] data, input logic bad_parity);
	logic [10:0] bits;
	int codes_before;
	int errs_before;
	int i;
	bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
	last_byte = data;
	bad_frame = bad_parity;
	codes_before = code_cnt;
	errs_before = ferr_cnt;
	for (i = 0; i < 11; i++) begin
		ps2_data_drv = bits[i];
		wait_cycles(half_period);
		ps2_clk_drv = 1'b0;
		wait_cycles(half_period);
		ps2_clk_drv = 1'b1;
	end
	ps2_data_drv = 1'b1;
	// idle gap, long enough for the filters and the FSM.
	wait_cycles(2 * half_period);
	check_count("ps2_code_new", code_cnt - codes_before, bad_parity ? 0 : 1);
	check_count("frame_err", ferr_cnt - errs_before, bad_parity ? 1 : 0);
endtask

task automatic press_key(input logic [7:0] code, input logic ext);
	logic [7:0] res;
	int ascii_before;
	if (ext) begin
		no_emit = 1'b1;
		send_frame(8'hE0, 1'b0);
	end
	res = expected_char(code, ext);
	exp_ascii = res[6:0];
	no_emit = 1'b0;
	ascii_before = ascii_cnt;
	send_frame(code, 1'b0);
	check_count("ascii_new", ascii_cnt - ascii_before, res[7] ? 1 : 0);
	update_mods(code, ext, 1'b1);
endtask

task automatic release_key(input logic [7:0] code, input logic ext);
	int ascii_before;
	ascii_before = ascii_cnt;
	no_emit = 1'b1;
	if (ext) begin
		send_frame(8'hE0, 1'b0);
	end
	send_frame(8'hF0, 1'b0);
	send_frame(code, 1'b0);
	no_emit = 1'b0;
	check_count("ascii_new", ascii_cnt - ascii_before, 0);
	update_mods(code, ext, 1'b0);
endtask

// ==== bench/ps2_keyboard_tb.sv ====
`timescale 1ns/10ps

module ps2_keyboard_tb
	import ps2_pkg::*;
;

	// set 2 make codes for a..z.
	localparam logic [7:0] letter_codes [26] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
		8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
	};
	// frames sent over all tests, rounded up.
	localparam int planned_frames = 70;

	logic clk = 1'b0;
	logic rst;
	logic ps2_clk_drv;
	logic ps2_data_drv;
	logic ps2_code_new;
	logic [7:0] ps2_code;
	logic frame_err;
	logic ascii_new;
	logic [6:0] ascii_code;

	// reference model state.
	key_mods_t model_mods = '0;
	logic [7:0] last_byte = 8'h00;
	logic [6:0] exp_ascii = 7'h00;
	logic bad_frame = 1'b0;
	logic no_emit = 1'b0;

	int code_cnt = 0;
	int ferr_cnt = 0;
	int ascii_cnt = 0;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int seed = 33758;
	int errs_at_start;
	int n;

	`include "ps2_tb_tasks.svh"

	always #10 clk = ~clk;

	ps2_keyboard #(
		.debounce_bits(3)
	) dut_i (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk_drv),
		.ps2_data    (ps2_data_drv),
		.ps2_code_new(ps2_code_new),
		.ps2_code    (ps2_code),
		.frame_err   (frame_err),
		.ascii_new   (ascii_new),
		.ascii_code  (ascii_code)
	);

	always @(posedge clk) begin
		code_cnt <= code_cnt + (ps2_code_new ? 1 : 0);
		ferr_cnt <= ferr_cnt + (frame_err ? 1 : 0);
		ascii_cnt <= ascii_cnt + (ascii_new ? 1 : 0);
	end

	code_match: assert property (@(posedge clk) disable iff (rst)
		ps2_code_new |-> ps2_code == last_byte)
	else begin
		$display("ERR ps2_code: expected %h got %h", last_byte, ps2_code);
		err_cnt++;
	end

	ascii_latency: assert property (@(posedge clk) disable iff (rst)
		ascii_new |-> $past(ps2_code_new, 4))
	else begin
		$display("ascii_new came without a received code four cycles before");
		err_cnt++;
	end

	ascii_match: assert property (@(posedge clk) disable iff (rst)
		ascii_new |-> ascii_code == exp_ascii)
	else begin
		$display("ERR ascii_code: expected %h got %h", exp_ascii, ascii_code);
		err_cnt++;
	end

	ascii_quiet: assert property (@(posedge clk) disable iff (rst)
		ascii_new |-> !no_emit)
	else begin
		$display("ascii_new fired during a break or prefix sequence");
		err_cnt++;
	end

	err_expected: assert property (@(posedge clk) disable iff (rst)
		frame_err |-> bad_frame)
	else begin
		$display("frame_err fired on a correct frame");
		err_cnt++;
	end

	// mapped flag and code, from the keyboard rules and the model mods.
	function automatic logic [7:0] expected_char(input logic [7:0] code, input logic ext);
		int idx;
		int i;
		logic shift;
		logic ctrl;
		idx = -1;
		for (i = 0; i < 26; i++) begin
			if (letter_codes[i] == code) begin
				idx = i;
			end
		end
		shift = model_mods.shift_l | model_mods.shift_r;
		ctrl = model_mods.ctrl_l | model_mods.ctrl_r;
		if (idx >= 0) begin
			if (ctrl) begin
				return {1'b1, 7'(idx + 1)};
			end
			return {1'b1, ((shift != model_mods.caps_lock) ? 7'h41 : 7'h61) + 7'(idx)};
		end
		if (ctrl) begin
			return 8'h00;
		end
		case (code)
			8'h16: return {1'b1, shift ? 7'h21 : 7'h31};
			8'h1E: return {1'b1, shift ? 7'h40 : 7'h32};
			8'h45: return {1'b1, shift ? 7'h29 : 7'h30};
			8'h29: return {1'b1, 7'h20};
			8'h5A: return {1'b1, 7'h0D};
			8'h71: return {ext, 7'h7F};
			default: return 8'h00;
		endcase
	endfunction

	task automatic update_mods(input logic [7:0] code, input logic ext, input logic make);
		if (code == 8'h58 && make) begin
			model_mods.caps_lock = ~model_mods.caps_lock;
		end
		if (code == 8'h12) begin
			model_mods.shift_l = make;
		end
		if (code == 8'h59) begin
			model_mods.shift_r = make;
		end
		if (code == 8'h14) begin
			if (ext) begin
				model_mods.ctrl_r = make;
			end else begin
				model_mods.ctrl_l = make;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %s: passed", name);
		end else begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		#(planned_frames * frame_cycles * 20 * 2);
		$display("timeout: the tests did not finish in the expected time");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		ps2_clk_drv = 1'b1;
		ps2_data_drv = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		wait_cycles(20);

		errs_at_start = err_cnt;
		for (n = 0; n < 20; n++) begin
			press_key(letter_codes[$unsigned($random(seed)) % 26], 1'b0);
		end
		report_test("frame reception", errs_at_start);

		errs_at_start = err_cnt;
		press_key(8'h1C, 1'b0);
		release_key(8'h1C, 1'b0);
		press_key(8'h71, 1'b1);
		release_key(8'h71, 1'b1);
		report_test("make and break", errs_at_start);

		errs_at_start = err_cnt;
		press_key(8'h12, 1'b0);
		press_key(8'h32, 1'b0);
		press_key(8'h16, 1'b0);
		release_key(8'h12, 1'b0);
		press_key(8'h32, 1'b0);
		press_key(8'h16, 1'b0);
		press_key(8'h59, 1'b0);
		press_key(8'h21, 1'b0);
		press_key(8'h1E, 1'b0);
		release_key(8'h59, 1'b0);
		press_key(8'h58, 1'b0);
		release_key(8'h58, 1'b0);
		press_key(8'h23, 1'b0);
		press_key(8'h12, 1'b0);
		press_key(8'h23, 1'b0);
		release_key(8'h12, 1'b0);
		press_key(8'h58, 1'b0);
		release_key(8'h58, 1'b0);
		press_key(8'h45, 1'b0);
		report_test("shift and caps lock", errs_at_start);

		errs_at_start = err_cnt;
		press_key(8'h14, 1'b0);
		press_key(8'h1C, 1'b0);
		press_key(8'h1A, 1'b0);
		release_key(8'h14, 1'b0);
		press_key(8'h1C, 1'b0);
		press_key(8'h14, 1'b1);
		press_key(8'h21, 1'b0);
		release_key(8'h14, 1'b1);
		press_key(8'h21, 1'b0);
		report_test("control", errs_at_start);

		// a bad frame must not reach the FSM.
		errs_at_start = err_cnt;
		no_emit = 1'b1;
		send_frame(8'h2D, 1'b1);
		press_key(8'h2D, 1'b0);
		report_test("parity error", errs_at_start);

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
rtl/ps2_pkg.sv
rtl/ps2_debounce.sv
rtl/ps2_frame_rx.sv
rtl/ps2_ascii_map.sv
rtl/ps2_key_fsm.sv
rtl/ps2_keyboard.sv
bench/ps2_keyboard_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module ps2_keyboard_tb \
	-o ps2_keyboard_sim

./obj_dir/ps2_keyboard_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0
